/* verilog.f */
rtl/axis_in_cfg_pkg.sv
rtl/axis_in_regs_pkg.sv
rtl/axis_in_packer.sv
rtl/axis_in_fifo.sv
rtl/axis_in_drain.sv
rtl/axis_in_csr.sv
rtl/axis_in_top.sv
tb/axis_in_assert.sv
tb/axis_in_tb.sv

/* tb/axis_in_tb.sv */
`timescale 1ns/1ps
// Testbench for axis_in_top with a packing reference model
// Bus and stream tasks, compare tasks, directed tests and timeout
module axis_in_tb;
   import axis_in_cfg_pkg::*;
   import axis_in_regs_pkg::*;

   localparam logic [31:0] SEED = 32'hc9993c98;
   // Directed tests need about 400 cycles, random ready roughly doubles it
   localparam int RUN_CYCLES     = 800;
   localparam int TIMEOUT_CYCLES = 5 * RUN_CYCLES;
   localparam int STALL_CYCLES   = 16;

   logic       clk_i;
   logic       rst_i;
   logic       axis_tvalid_i;
   beat_t      axis_tdata_i;
   logic       axis_tlast_i;
   logic       axis_tready_o;
   logic       sys_tvalid_o;
   data_word_t sys_tdata_o;
   logic       sys_tready_i;
   logic       csr_en_i;
   logic       csr_we_i;
   csr_addr_e  csr_addr_i;
   data_word_t csr_wdata_i;
   data_word_t csr_rdata_o;
   logic       interrupt_o;

   // Reference model state
   data_word_t model_q[$];
   data_word_t model_word;
   int         model_lane;
   int         cycle_count = 0;

   axis_in_top DUT (.*);

   initial begin
      clk_i = 1'b0;
      forever #4 clk_i = ~clk_i;
   end

   task automatic end_with_failure();
      $display("STATUS: FAIL");
      $fatal(1, "Simulation stopped on failure");
   endtask

   always @(posedge clk_i) begin
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
         $display("Timeout: the run took too long, over %0d cycles", TIMEOUT_CYCLES);
         end_with_failure();
      end else if (DUT.u_assert.fail_count != 0) begin
         $display("A protocol assertion on the stream ports failed");
         end_with_failure();
      end
   end

   task automatic check_word(input string name, input data_word_t exp, input data_word_t act);
      if (exp !== act) begin
         $display("Error: %s expected %h got %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_level(input string name, input level_t exp, input level_t act);
      if (exp !== act) begin
         $display("Error: %s expected %h got %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("Error: %s expected %h got %h", name, exp, act);
         end_with_failure();
      end
   endtask

   // Packing rules: first beat in lane 0, zero lanes after an early tlast
   task automatic model_beat(input beat_t b, input logic last);
      model_word[model_lane*TDATA_W +: TDATA_W] = b;
      model_lane++;
      while (last && model_lane < LANES) begin
         model_word[model_lane*TDATA_W +: TDATA_W] = '0;
         model_lane++;
      end
      if (model_lane == LANES) begin
         model_q.push_back(model_word);
         model_word = '0;
         model_lane = 0;
      end
   endtask

   task automatic model_reset();
      model_q.delete();
      model_word = '0;
      model_lane = 0;
   endtask

   task automatic expect_word(input string name, input data_word_t act);
      if (model_q.size() == 0) begin
         $display("A word arrived on %s that the model did not produce", name);
         end_with_failure();
      end else begin
         check_word(name, model_q.pop_front(), act);
      end
   endtask

   task automatic csr_write(input csr_addr_e addr, input data_word_t data);
      csr_en_i    = 1'b1;
      csr_we_i    = 1'b1;
      csr_addr_i  = addr;
      csr_wdata_i = data;
      @(posedge clk_i);
      #1;
      csr_en_i = 1'b0;
      csr_we_i = 1'b0;
   endtask

   task automatic csr_read(input csr_addr_e addr, output data_word_t data);
      csr_en_i   = 1'b1;
      csr_we_i   = 1'b0;
      csr_addr_i = addr;
      @(posedge clk_i);
      #1;
      csr_en_i = 1'b0;
      data     = csr_rdata_o;
   endtask

   function automatic data_word_t ctrl_word(input logic en, input drain_mode_e mode,
                                            input logic srst);
      data_word_t w;
      w = '0;
      w[CTRL_EN_BIT]   = en;
      w[CTRL_MODE_BIT] = mode;
      w[CTRL_SRST_BIT] = srst;
      return w;
   endfunction

   // Extra cycle lets the pulse clear the datapath
   task automatic soft_reset(input drain_mode_e mode);
      csr_write(REG_CTRL, ctrl_word(1'b1, mode, 1'b1));
      @(posedge clk_i);
      #1;
      model_reset();
   endtask

   // max_wait of 0 waits for ready without limit
   task automatic send_beat(input beat_t b, input logic last, input int max_wait,
                            output bit accepted);
      int waited;
      waited        = 0;
      axis_tvalid_i = 1'b1;
      axis_tdata_i  = b;
      axis_tlast_i  = last;
      while (!axis_tready_o && (max_wait == 0 || waited < max_wait)) begin
         @(posedge clk_i);
         #1;
         waited++;
      end
      accepted = axis_tready_o;
      @(posedge clk_i);
      #1;
      if (accepted) begin
         model_beat(b, last);
      end
      axis_tvalid_i = 1'b0;
      axis_tlast_i  = 1'b0;
   endtask

   task automatic send_beats(input int n, input logic last);
      bit acc;
      for (int i = 0; i < n; i++) begin
         send_beat(beat_t'($urandom), last && (i == n - 1), 0, acc);
      end
   endtask

   task automatic take_word(input bit rand_ready, output data_word_t w);
      bit done;
      bit rdy;
      done = 1'b0;
      while (!done) begin
         rdy          = rand_ready ? bit'($urandom % 2) : 1'b1;
         sys_tready_i = rdy;
         if (sys_tvalid_o && rdy) begin
            w    = sys_tdata_o;
            done = 1'b1;
         end
         @(posedge clk_i);
         #1;
      end
      sys_tready_i = 1'b0;
   endtask

   task automatic take_words(input int n, input bit rand_ready);
      data_word_t w;
      for (int i = 0; i < n; i++) begin
         take_word(rand_ready, w);
         expect_word("sys_tdata_o", w);
      end
   endtask

   // Software polls for a word, then pops it
   task automatic cpu_read_word();
      data_word_t d;
      do begin
         csr_read(REG_STATUS, d);
      end while (d[STAT_EMPTY_BIT]);
      csr_read(REG_DATA, d);
      expect_word("csr_rdata_o", d);
   endtask

   task automatic reset_defaults();
      data_word_t d;
      check_bit("axis_tready_o", 1'b0, axis_tready_o);
      check_bit("sys_tvalid_o", 1'b0, sys_tvalid_o);
      check_bit("interrupt_o", 1'b0, interrupt_o);
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS empty", 1'b1, d[STAT_EMPTY_BIT]);
      csr_read(REG_LEVEL, d);
      check_level("REG_LEVEL", '0, level_t'(d));
      csr_read(REG_THRESH, d);
      check_level("REG_THRESH", level_t'(1), level_t'(d));
   endtask

   task automatic stream_packing();
      data_word_t d;
      csr_write(REG_CTRL, ctrl_word(1'b1, MODE_STREAM, 1'b0));
      fork
         send_beats(12, 1'b1);
         take_words(3, 1'b1);
      join
      csr_read(REG_NWORDS, d);
      check_word("REG_NWORDS", 32'd12, d);
   endtask

   task automatic tlast_padding();
      data_word_t d;
      soft_reset(MODE_STREAM);
      fork
         send_beats(5, 1'b1);
         take_words(2, 1'b1);
      join
      csr_read(REG_NWORDS, d);
      check_word("REG_NWORDS", 32'd8, d);
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS packet end", 1'b1, d[STAT_END_BIT]);
   endtask

   task automatic cpu_mode_reads();
      data_word_t d;
      soft_reset(MODE_CPU);
      csr_write(REG_THRESH, 32'd2);
      send_beats(8, 1'b1);
      // Input stays closed after the packet end
      axis_tvalid_i = 1'b1;
      axis_tdata_i  = beat_t'($urandom);
      for (int i = 0; i < 4; i++) begin
         check_bit("axis_tready_o", 1'b0, axis_tready_o);
         @(posedge clk_i);
         #1;
      end
      axis_tvalid_i = 1'b0;
      csr_read(REG_LEVEL, d);
      check_level("REG_LEVEL", level_t'(2), level_t'(d));
      check_bit("interrupt_o", 1'b1, interrupt_o);
      cpu_read_word();
      cpu_read_word();
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS empty", 1'b1, d[STAT_EMPTY_BIT]);
      check_bit("interrupt_o", 1'b0, interrupt_o);
   endtask

   task automatic full_backpressure();
      data_word_t d;
      int         count;
      bit         acc;
      soft_reset(MODE_STREAM);
      sys_tready_i = 1'b0;
      count        = 0;
      do begin
         send_beat(beat_t'($urandom), 1'b0, STALL_CYCLES, acc);
         if (acc) begin
            count++;
         end
      end while (acc);
      check_word("accepted beats", data_word_t'((FIFO_DEPTH + 1) * LANES), data_word_t'(count));
      csr_read(REG_NWORDS, d);
      check_word("REG_NWORDS", data_word_t'(count), d);
      csr_read(REG_LEVEL, d);
      check_level("REG_LEVEL", level_t'(FIFO_DEPTH + 1), level_t'(d));
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS full", 1'b1, d[STAT_FULL_BIT]);
      take_words(FIFO_DEPTH + 1, 1'b0);
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS empty", 1'b1, d[STAT_EMPTY_BIT]);
   endtask

   task automatic soft_reset_clears();
      data_word_t d;
      sys_tready_i = 1'b0;
      send_beats(5, 1'b1);
      // Wait for the padded word to land
      do begin
         csr_read(REG_LEVEL, d);
      end while (level_t'(d) != level_t'(2));
      soft_reset(MODE_STREAM);
      csr_read(REG_LEVEL, d);
      check_level("REG_LEVEL", '0, level_t'(d));
      csr_read(REG_NWORDS, d);
      check_word("REG_NWORDS", '0, d);
      csr_read(REG_STATUS, d);
      check_bit("REG_STATUS packet end", 1'b0, d[STAT_END_BIT]);
      csr_read(REG_CTRL, d);
      check_bit("REG_CTRL enable", 1'b1, d[CTRL_EN_BIT]);
      check_bit("REG_CTRL mode", 1'b1, d[CTRL_MODE_BIT]);
   endtask

   initial begin
      void'($urandom(SEED));
      rst_i         = 1'b1;
      axis_tvalid_i = 1'b0;
      axis_tdata_i  = '0;
      axis_tlast_i  = 1'b0;
      sys_tready_i  = 1'b0;
      csr_en_i      = 1'b0;
      csr_we_i      = 1'b0;
      csr_addr_i    = REG_CTRL;
      csr_wdata_i   = '0;
      model_reset();
      repeat (2) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      reset_defaults();
      stream_packing();
      tlast_padding();
      cpu_mode_reads();
      full_backpressure();
      soft_reset_clears();
      if (DUT.u_assert.fail_count != 0) begin
         $display("Protocol assertions failed %0d times", DUT.u_assert.fail_count);
         end_with_failure();
      end else begin
         $display("STATUS: PASS");
         $finish;
      end
   end

endmodule

/* tb/axis_in_assert.sv */
`timescale 1ns/1ps
// Concurrent protocol checks on the stream ports of axis_in_top
// Bound into the top level and counting failures for the testbench
module axis_in_assert
   import axis_in_cfg_pkg::*;
(
   input logic       clk_i,
   input logic       rst_i,
   input logic       sw_rst_i,
   input logic       axis_tready_i,
   input logic       sys_tvalid_i,
   input data_word_t sys_tdata_i,
   input logic       sys_tready_i
);

   int unsigned fail_count = 0;

   // Output word held while the consumer stalls
   a_sys_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      sys_tvalid_i && !sys_tready_i && !sw_rst_i |=> sys_tvalid_i && $stable(sys_tdata_i))
      else begin
         fail_count++;
         $error("sys_tvalid_o or sys_tdata_o changed while sys_tready_i was low");
      end

   a_ready_after_rst: assert property (@(posedge clk_i) rst_i |=> !axis_tready_i)
      else begin
         fail_count++;
         $error("axis_tready_o high in the cycle after reset");
      end

   // Valid only drops after a transfer or a soft reset
   a_valid_fall: assert property (@(posedge clk_i) disable iff (rst_i)
      $fell(sys_tvalid_i) |-> $past(sys_tready_i || sw_rst_i))
      else begin
         fail_count++;
         $error("sys_tvalid_o fell without a transfer");
      end

endmodule

bind axis_in_top axis_in_assert u_assert (
   .clk_i        (clk_i),
   .rst_i        (rst_i),
   .sw_rst_i     (sw_rst),
   .axis_tready_i(axis_tready_o),
   .sys_tvalid_i (sys_tvalid_o),
   .sys_tdata_i  (sys_tdata_o),
   .sys_tready_i (sys_tready_i)
);

/* rtl/axis_in_top.sv */
`timescale 1ns/1ps
// AXI-Stream input peripheral top level
// Packer and register block side by side, feeding the drain
module axis_in_top
   import axis_in_cfg_pkg::*;
   import axis_in_regs_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   // AXI-Stream slave
   input  logic       axis_tvalid_i,
   input  beat_t      axis_tdata_i,
   input  logic       axis_tlast_i,
   output logic       axis_tready_o,
   // System stream master
   output logic       sys_tvalid_o,
   output data_word_t sys_tdata_o,
   input  logic       sys_tready_i,
   // Register bus
   input  logic       csr_en_i,
   input  logic       csr_we_i,
   input  csr_addr_e  csr_addr_i,
   input  data_word_t csr_wdata_i,
   output data_word_t csr_rdata_o,
   output logic       interrupt_o
);

   logic        sw_enable;
   drain_mode_e sw_mode;
   logic        sw_rst;
   level_t      threshold;
   logic        word_push;
   data_word_t  word_data;
   logic        fifo_full;
   logic        out_valid;
   data_word_t  out_data;
   level_t      level;
   logic        empty;
   logic        data_pop;
   data_word_t  nwords;
   logic        pkt_end;

   axis_in_packer u_packer (
      .clk_i        (clk_i),
      .rst_i        (rst_i),
      .sw_rst_i     (sw_rst),
      .sw_enable_i  (sw_enable),
      .sw_mode_i    (sw_mode),
      .axis_tvalid_i(axis_tvalid_i),
      .axis_tdata_i (axis_tdata_i),
      .axis_tlast_i (axis_tlast_i),
      .fifo_full_i  (fifo_full),
      .axis_tready_o(axis_tready_o),
      .word_push_o  (word_push),
      .word_data_o  (word_data),
      .nwords_o     (nwords),
      .pkt_end_o    (pkt_end)
   );

   axis_in_csr u_csr (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .csr_en_i   (csr_en_i),
      .csr_we_i   (csr_we_i),
      .csr_addr_i (csr_addr_i),
      .csr_wdata_i(csr_wdata_i),
      .out_valid_i(out_valid),
      .out_data_i (out_data),
      .level_i    (level),
      .empty_i    (empty),
      .full_i     (fifo_full),
      .nwords_i   (nwords),
      .pkt_end_i  (pkt_end),
      .csr_rdata_o(csr_rdata_o),
      .sw_enable_o(sw_enable),
      .sw_mode_o  (sw_mode),
      .sw_rst_o   (sw_rst),
      .threshold_o(threshold),
      .data_pop_o (data_pop)
   );

   axis_in_drain u_drain (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .sw_rst_i    (sw_rst),
      .sw_mode_i   (sw_mode),
      .threshold_i (threshold),
      .word_push_i (word_push),
      .word_data_i (word_data),
      .sys_tready_i(sys_tready_i),
      .data_pop_i  (data_pop),
      .fifo_full_o (fifo_full),
      .sys_tvalid_o(sys_tvalid_o),
      .sys_tdata_o (sys_tdata_o),
      .out_valid_o (out_valid),
      .out_data_o  (out_data),
      .level_o     (level),
      .empty_o     (empty),
      .interrupt_o (interrupt_o)
   );

endmodule

/* rtl/axis_in_csr.sv */
`timescale 1ns/1ps
// Software register block with registered read data
// Control, threshold, soft-reset pulse and CPU data pop
module axis_in_csr
   import axis_in_cfg_pkg::*;
   import axis_in_regs_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        csr_en_i,
   input  logic        csr_we_i,
   input  csr_addr_e   csr_addr_i,
   input  data_word_t  csr_wdata_i,
   input  logic        out_valid_i,
   input  data_word_t  out_data_i,
   input  level_t      level_i,
   input  logic        empty_i,
   input  logic        full_i,
   input  data_word_t  nwords_i,
   input  logic        pkt_end_i,
   output data_word_t  csr_rdata_o,
   output logic        sw_enable_o,
   output drain_mode_e sw_mode_o,
   output logic        sw_rst_o,
   output level_t      threshold_o,
   output logic        data_pop_o
);

   logic        wr_en;
   logic        rd_en;
   logic        cpu_data;
   logic        enable_q;
   drain_mode_e mode_q;
   logic        srst_q;
   level_t      thresh_q;
   data_word_t  rd_mux;

   assign wr_en = csr_en_i & csr_we_i;
   assign rd_en = csr_en_i & ~csr_we_i;

   // A word is available to software only in CPU mode
   assign cpu_data   = (mode_q == MODE_CPU) & out_valid_i;
   assign data_pop_o = rd_en & (csr_addr_i == REG_DATA) & cpu_data;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         enable_q <= 1'b0;
         mode_q   <= MODE_CPU;
         srst_q   <= 1'b0;
         thresh_q <= level_t'(THRESH_RST);
      end else begin
         // Self-clearing soft reset
         srst_q <= wr_en & (csr_addr_i == REG_CTRL) & csr_wdata_i[CTRL_SRST_BIT];
         if (wr_en) begin
            case (csr_addr_i)
               REG_CTRL: begin
                  enable_q <= csr_wdata_i[CTRL_EN_BIT];
                  mode_q   <= drain_mode_e'(csr_wdata_i[CTRL_MODE_BIT]);
               end
               REG_THRESH: begin
                  thresh_q <= csr_wdata_i[LEVEL_W-1:0];
               end
               default: begin
               end
            endcase
         end
      end
   end

   always_comb begin
      rd_mux = '0;
      case (csr_addr_i)
         REG_CTRL: begin
            rd_mux[CTRL_EN_BIT]   = enable_q;
            rd_mux[CTRL_MODE_BIT] = mode_q;
         end
         REG_THRESH: rd_mux = DATA_W'(thresh_q);
         REG_STATUS: begin
            rd_mux[STAT_EMPTY_BIT] = empty_i;
            rd_mux[STAT_FULL_BIT]  = full_i;
            rd_mux[STAT_END_BIT]   = pkt_end_i;
         end
         REG_LEVEL:  rd_mux = DATA_W'(level_i);
         REG_NWORDS: rd_mux = nwords_i;
         // Zero when nothing is waiting
         REG_DATA:   rd_mux = cpu_data ? out_data_i : '0;
         default:    rd_mux = '0;
      endcase
   end

   // Read data holds until the next read
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         csr_rdata_o <= '0;
      end else if (rd_en) begin
         csr_rdata_o <= rd_mux;
      end
   end

   assign sw_enable_o = enable_q;
   assign sw_mode_o   = mode_q;
   assign sw_rst_o    = srst_q;
   assign threshold_o = thresh_q;

endmodule

/* rtl/axis_in_drain.sv */
`timescale 1ns/1ps
// Word FIFO plus output register, routed to the stream port or the CPU
// Combined level, empty flag and threshold interrupt
module axis_in_drain
   import axis_in_cfg_pkg::*;
   import axis_in_regs_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        sw_rst_i,
   input  drain_mode_e sw_mode_i,
   input  level_t      threshold_i,
   input  logic        word_push_i,
   input  data_word_t  word_data_i,
   input  logic        sys_tready_i,
   input  logic        data_pop_i,
   output logic        fifo_full_o,
   output logic        sys_tvalid_o,
   output data_word_t  sys_tdata_o,
   output logic        out_valid_o,
   output data_word_t  out_data_o,
   output level_t      level_o,
   output logic        empty_o,
   output logic        interrupt_o
);

   logic       clr;
   logic       stream;
   logic       take;
   logic       fifo_pop;
   logic       fifo_empty;
   data_word_t fifo_data;
   level_t     fifo_level;
   logic       rd_pend_q;
   logic       out_valid_q;
   data_word_t out_data_q;
   level_t     level_sum;

   assign clr    = rst_i | sw_rst_i;
   assign stream = (sw_mode_i == MODE_STREAM);
   assign take   = out_valid_q & (stream ? sys_tready_i : data_pop_i);

   // Fetch only when the output register is free by the time data returns
   assign fifo_pop = ~fifo_empty & ~rd_pend_q & (~out_valid_q | take);

   axis_in_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_i      (clr),
      .push_i     (word_push_i),
      .push_data_i(word_data_i),
      .pop_i      (fifo_pop),
      .pop_data_o (fifo_data),
      .empty_o    (fifo_empty),
      .full_o     (fifo_full_o),
      .level_o    (fifo_level)
   );

   always_ff @(posedge clk_i) begin
      if (clr) begin
         rd_pend_q   <= 1'b0;
         out_valid_q <= 1'b0;
      end else begin
         rd_pend_q <= fifo_pop;
         if (rd_pend_q) begin
            out_valid_q <= 1'b1;
         end else if (take) begin
            out_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_pend_q) begin
         out_data_q <= fifo_data;
      end
   end

   assign sys_tvalid_o = out_valid_q & stream;
   assign sys_tdata_o  = out_data_q;
   assign out_valid_o  = out_valid_q;
   assign out_data_o   = out_data_q;

   // A word in flight from the FIFO still counts
   assign level_sum   = fifo_level + level_t'(out_valid_q) + level_t'(rd_pend_q);
   assign level_o     = level_sum;
   assign empty_o     = fifo_empty & ~out_valid_q & ~rd_pend_q;
   assign interrupt_o = (level_sum >= threshold_i);

endmodule

/* rtl/axis_in_fifo.sv */
`timescale 1ns/1ps
// Synchronous word FIFO with registered read port
// Reports level, empty and full
module axis_in_fifo
   import axis_in_cfg_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_i,
   input  logic       push_i,
   input  data_word_t push_data_i,
   input  logic       pop_i,
   output data_word_t pop_data_o,
   output logic       empty_o,
   output logic       full_o,
   output level_t     level_o
);

   data_word_t             mem [FIFO_DEPTH];
   logic [FIFO_ADDR_W-1:0] wr_ptr_q;
   logic [FIFO_ADDR_W-1:0] rd_ptr_q;
   level_t                 count_q;
   logic                   push_ok;
   logic                   pop_ok;

   assign full_o  = (count_q == level_t'(FIFO_DEPTH));
   assign empty_o = (count_q == '0);
   assign level_o = count_q;

   // Overflow and underflow attempts are dropped
   assign push_ok = push_i & ~full_o;
   assign pop_ok  = pop_i & ~empty_o;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push_ok) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push_ok, pop_ok})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Storage
   always_ff @(posedge clk_i) begin
      if (push_ok) begin
         mem[wr_ptr_q] <= push_data_i;
      end
   end

   // Read data one cycle after the pop
   always_ff @(posedge clk_i) begin
      if (pop_ok) begin
         pop_data_o <= mem[rd_ptr_q];
      end
   end

endmodule

/* rtl/axis_in_packer.sv */
`timescale 1ns/1ps
// AXI-Stream beat acceptance and lane packing with tlast padding
// Accepted-lane counter and packet-end flag
module axis_in_packer
   import axis_in_cfg_pkg::*;
   import axis_in_regs_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        sw_rst_i,
   input  logic        sw_enable_i,
   input  drain_mode_e sw_mode_i,
   input  logic        axis_tvalid_i,
   input  beat_t       axis_tdata_i,
   input  logic        axis_tlast_i,
   input  logic        fifo_full_i,
   output logic        axis_tready_o,
   output logic        word_push_o,
   output data_word_t  word_data_o,
   output data_word_t  nwords_o,
   output logic        pkt_end_o
);

   pack_state_e       state_q;
   pack_state_e       state_d;
   logic [LANE_W-1:0] lane_q;
   data_word_t        word_q;
   data_word_t        word_nxt;
   beat_t             lane_data;
   logic              clr;
   logic              last_lane;
   logic              beat_acc;
   logic              pad_wr;
   logic              lane_wr;
   logic              cnt_done_q;
   logic              pkt_end_q;
   data_word_t        nwords_q;

   assign clr       = rst_i | sw_rst_i;
   assign last_lane = (lane_q == LANE_W'(LANES - 1));

   // No beats while padding; CPU mode stops after the first packet end
   assign axis_tready_o = sw_enable_i & ~fifo_full_i & (state_q == PACK_FILL)
                          & ~((sw_mode_i == MODE_CPU) & pkt_end_q);

   assign beat_acc  = axis_tvalid_i & axis_tready_o;
   // One zero lane per cycle while there is room for the word
   assign pad_wr    = (state_q == PACK_PAD) & ~fifo_full_i;
   assign lane_wr   = beat_acc | pad_wr;
   assign lane_data = beat_acc ? axis_tdata_i : '0;

   // Current word with this cycle's lane merged in
   always_comb begin
      word_nxt = word_q;
      word_nxt[lane_q*TDATA_W +: TDATA_W] = lane_data;
   end

   always_comb begin
      state_d = state_q;
      case (state_q)
         PACK_FILL: begin
            if (beat_acc && axis_tlast_i && !last_lane) begin
               state_d = PACK_PAD;
            end
         end
         PACK_PAD: begin
            if (pad_wr && last_lane) begin
               state_d = PACK_FILL;
            end
         end
         default: begin
            state_d = PACK_FILL;
         end
      endcase
   end

   // Push on the same edge as the last lane
   assign word_push_o = lane_wr & last_lane;
   assign word_data_o = word_nxt;

   always_ff @(posedge clk_i) begin
      if (clr) begin
         state_q    <= PACK_FILL;
         lane_q     <= '0;
         pkt_end_q  <= 1'b0;
         cnt_done_q <= 1'b0;
         nwords_q   <= '0;
      end else begin
         state_q <= state_d;
         if (lane_wr) begin
            lane_q <= lane_q + 1'b1;
         end
         if (beat_acc && axis_tlast_i) begin
            pkt_end_q <= 1'b1;
         end
         // Count stops once the first packet's word is complete
         if (word_push_o && ((beat_acc && axis_tlast_i) || state_q == PACK_PAD)) begin
            cnt_done_q <= 1'b1;
         end
         if (lane_wr && !cnt_done_q) begin
            nwords_q <= nwords_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (lane_wr) begin
         word_q <= word_nxt;
      end
   end

   assign nwords_o  = nwords_q;
   assign pkt_end_o = pkt_end_q;

endmodule

/* rtl/axis_in_regs_pkg.sv */
// Register map of the software interface
// Address and mode enums, field positions and reset values
package axis_in_regs_pkg;

   // Register addresses
   typedef enum logic [2:0] {
      REG_CTRL   = 3'd0,
      REG_THRESH = 3'd1,
      REG_STATUS = 3'd2,
      REG_LEVEL  = 3'd3,
      REG_NWORDS = 3'd4,
      REG_DATA   = 3'd5
   } csr_addr_e;

   // Output stage consumer
   typedef enum logic {
      MODE_CPU    = 1'b0,
      MODE_STREAM = 1'b1
   } drain_mode_e;

   // REG_CTRL fields
   localparam int CTRL_EN_BIT   = 0;
   localparam int CTRL_MODE_BIT = 1;
   // Write 1 for a one-cycle soft reset
   localparam int CTRL_SRST_BIT = 2;

   // REG_STATUS fields
   localparam int STAT_EMPTY_BIT = 0;
   localparam int STAT_FULL_BIT  = 1;
   localparam int STAT_END_BIT   = 2;

   // Interrupt threshold after reset
   localparam int THRESH_RST = 1;

endpackage

/* rtl/axis_in_cfg_pkg.sv */
// Stream path widths and FIFO depth
// Shared data types of the packer, FIFO and drain
package axis_in_cfg_pkg;

   // Beat and word widths
   localparam int TDATA_W = 8;
   localparam int DATA_W  = 32;

   // Lanes per packed word
   localparam int LANES  = DATA_W / TDATA_W;
   localparam int LANE_W = $clog2(LANES);

   // Word FIFO
   localparam int FIFO_ADDR_W = 3;
   localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;

   // Holds FIFO_DEPTH plus the word in the output register
   localparam int LEVEL_W = FIFO_ADDR_W + 2;

   typedef logic [TDATA_W-1:0] beat_t;
   typedef logic [DATA_W-1:0]  data_word_t;
   typedef logic [LEVEL_W-1:0] level_t;

   // Packer FSM
   typedef enum logic {
      PACK_FILL = 1'b0,
      PACK_PAD  = 1'b1
   } pack_state_e;

endpackage
